//--- rtl/castout_fmt_pkg.sv
package castout_fmt_pkg;

  // Half precision source lane.
  typedef struct packed {
    logic       sign;
    logic [4:0] exp;    // Bias 15.
    logic [9:0] man;
  } fp16_t;

  typedef struct packed {
    logic       sign;
    logic [4:0] exp;    // Bias 15, same range as FP16.
    logic [1:0] man;
  } fp8_e5m2_t;

  typedef struct packed {
    logic       sign;
    logic [3:0] exp;    // Bias 7.
    logic [2:0] man;
  } fp8_e4m3_t;

  // One result byte, read as either FP8 flavour.
  typedef union packed {
    logic [7:0] raw;
    fp8_e5m2_t  e5m2;
    fp8_e4m3_t  e4m3;
  } fp8_u;

  typedef enum logic {
    FMT_E5M2 = 1'b0,
    FMT_E4M3 = 1'b1
  } fp8_fmt_e;

  // Magnitude codes, sign bit excluded.
  localparam logic [6:0] E4M3_MAX_MAG = 7'h7E;  // 448.
  localparam logic [6:0] E4M3_NAN     = 7'h7F;
  localparam logic [6:0] E5M2_QNAN    = 7'h7E;

endpackage

//--- rtl/castout_bus_pkg.sv
package castout_bus_pkg;

  // Store side.
  localparam int unsigned ADDR_W = 32;  // Byte address of one row write.
  localparam int unsigned ROW_W  = 16;  // Rows per job.

  // Datapath.
  localparam int unsigned LANE_W = 16;  // One FP16 value.
  localparam int unsigned BYTE_W = 8;   // One FP8 value, also the byte enable granule.

endpackage

//--- rtl/castout_lane_cast.sv
`timescale 1ns/10ps

module castout_lane_cast
  import castout_fmt_pkg::*;
(
  input  fp16_t    lane_i,
  input  fp8_fmt_e fmt_i,
  output fp8_u     byte_o
);

  logic        is_nan;
  logic        is_inf;
  logic [7:0]  e5_sum;
  logic [10:0] sig;
  logic [3:0]  e4_exp;
  logic [7:0]  e4_norm_sum;
  logic [4:0]  sub_sh;
  logic [18:0] sub_tmp;
  logic [7:0]  e4_sub_sum;
  fp8_u        e5_byte;
  fp8_u        e4_byte;

  // Round to nearest even on a kept magnitude. The carry may ripple into the exponent.
  function automatic logic [7:0] rne(input logic [6:0] keep, input logic guard,
                                     input logic sticky);
    logic up;
    up = guard & (sticky | keep[0]);
    return {1'b0, keep} + {7'd0, up};
  endfunction

  assign is_nan = (lane_i.exp == 5'h1F) && (lane_i.man != '0);
  assign is_inf = (lane_i.exp == 5'h1F) && (lane_i.man == '0);

  // E5M2 shares the FP16 exponent, subnormals included.
  assign e5_sum = rne({lane_i.exp, lane_i.man[9:8]}, lane_i.man[7], |lane_i.man[6:0]);

  always_comb begin
    if (is_nan) begin
      e5_byte.raw = {lane_i.sign, E5M2_QNAN};
    end else if (is_inf || (e5_sum >= 8'h7C)) begin
      e5_byte.e5m2.sign = lane_i.sign;            // Overflow goes to infinity.
      e5_byte.e5m2.exp  = '1;
      e5_byte.e5m2.man  = '0;
    end else begin
      e5_byte.raw = {lane_i.sign, e5_sum[6:0]};
    end
  end

  assign sig    = {1'b1, lane_i.man};             // Hidden bit for normal inputs.
  assign e4_exp = lane_i.exp[3:0] - 4'd8;         // Rebias 15 to 7 for exponents 9 to 23.

  assign e4_norm_sum = rne({e4_exp, lane_i.man[9:7]}, lane_i.man[6],
                           |lane_i.man[5:0]);

  // Below 2^-6 the value is counted in units of 2^-9.
  assign sub_sh     = 5'd8 - lane_i.exp;
  assign sub_tmp    = {sig, 8'b0} >> sub_sh;
  assign e4_sub_sum = rne({4'b0, sub_tmp[18:16]}, sub_tmp[15], |sub_tmp[14:0]);

  always_comb begin
    if (is_nan) begin
      e4_byte.raw = {lane_i.sign, E4M3_NAN};
    end else if (is_inf || (lane_i.exp >= 5'd24)) begin
      e4_byte.raw = {lane_i.sign, E4M3_MAX_MAG};  // Saturate since E4M3 has no infinity.
    end else if (lane_i.exp >= 5'd9) begin
      if (e4_norm_sum >= 8'h7F) begin
        e4_byte.raw = {lane_i.sign, E4M3_MAX_MAG};
      end else begin
        e4_byte.raw = {lane_i.sign, e4_norm_sum[6:0]};
      end
    end else if (lane_i.exp != '0) begin
      e4_byte.raw = {lane_i.sign, e4_sub_sum[6:0]}; // May round up to the smallest normal.
    end else begin
      e4_byte.e4m3.sign = lane_i.sign;            // FP16 subnormals flush to zero.
      e4_byte.e4m3.exp  = '0;
      e4_byte.e4m3.man  = '0;
    end
  end

  assign byte_o = (fmt_i == FMT_E4M3) ? e4_byte : e5_byte;

endmodule

//--- rtl/castout_row_seq.sv
`timescale 1ns/10ps

module castout_row_seq
  import castout_bus_pkg::*;
  import castout_fmt_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  logic [ADDR_W-1:0]             base_addr_i,
  input  logic [ADDR_W-1:0]             stride_i,
  input  logic [ROW_W-1:0]              rows_i,
  input  logic                          cast_i,
  input  fp8_fmt_e                      dst_fmt_i,
  input  logic                          valid_i,
  input  logic [NUM_LANES*LANE_W-1:0]   data_i,
  output logic                          busy_o,
  output logic                          seq_valid_o,
  output logic [NUM_LANES*LANE_W-1:0]   seq_data_o,
  output logic [ADDR_W-1:0]             seq_addr_o,
  output logic                          seq_last_o,
  output logic                          seq_cast_o,
  output fp8_fmt_e                      seq_fmt_o
);

  logic              busy_q;
  logic [ROW_W-1:0]  rows_left_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic              cast_q;
  fp8_fmt_e          fmt_q;
  logic              job_go;
  logic              row_ok;
  logic              last_row;

  assign job_go   = start_i && !busy_q;            // New job only when idle.
  assign row_ok   = valid_i && busy_q;             // Strobes outside a job are dropped.
  assign last_row = (rows_left_q == ROW_W'(1));
  assign busy_o   = busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q      <= 1'b0;
      rows_left_q <= '0;
      seq_valid_o <= 1'b0;
    end else begin
      seq_valid_o <= row_ok;
      if (job_go) begin
        busy_q      <= (rows_i != '0);             // Zero-row job never goes busy.
        rows_left_q <= rows_i;
      end else if (row_ok) begin
        rows_left_q <= rows_left_q - 1'b1;
        if (last_row) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_go) begin
      addr_q   <= base_addr_i;
      stride_q <= stride_i;
      cast_q   <= cast_i;
      fmt_q    <= dst_fmt_i;
    end else if (row_ok) begin
      addr_q <= addr_q + stride_q;                 // Address of the next row.
    end
    if (row_ok) begin
      seq_data_o <= data_i;
      seq_addr_o <= addr_q;
      seq_last_o <= last_row;
      seq_cast_o <= cast_q;
      seq_fmt_o  <= fmt_q;
    end
  end

  // The engine must not restart a job on the same cycle it delivers a row.
  a_no_start_with_row : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) busy_q |-> !(start_i && valid_i)
  ) else $error("start_i and valid_i high together while busy");

endmodule

//--- rtl/castout_array.sv
`timescale 1ns/10ps

module castout_array
  import castout_bus_pkg::*;
  import castout_fmt_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          seq_valid_i,
  input  logic [NUM_LANES*LANE_W-1:0]   seq_data_i,
  input  logic [ADDR_W-1:0]             seq_addr_i,
  input  logic                          seq_last_i,
  input  logic                          seq_cast_i,
  input  fp8_fmt_e                      seq_fmt_i,
  output logic                          arr_valid_o,
  output logic [NUM_LANES*LANE_W-1:0]   arr_data_o,
  output logic [ADDR_W-1:0]             arr_addr_o,
  output logic                          arr_last_o,
  output logic                          arr_cast_o
);

  localparam int unsigned DATA_W = NUM_LANES * LANE_W;
  localparam int unsigned PACK_W = NUM_LANES * BYTE_W;  // Low half of the word.

  fp8_u              lane_byte [NUM_LANES];
  logic [PACK_W-1:0] packed_bytes;
  logic [DATA_W-1:0] cast_word;

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    castout_lane_cast lane_cast_i (
      .lane_i (fp16_t'(seq_data_i[k*LANE_W +: LANE_W])),
      .fmt_i  (seq_fmt_i),
      .byte_o (lane_byte[k])
    );
    assign packed_bytes[k*BYTE_W +: BYTE_W] = lane_byte[k].raw;  // Lane k to byte k.
  end

  assign cast_word = {{(DATA_W - PACK_W){1'b0}}, packed_bytes};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      arr_valid_o <= 1'b0;
    end else begin
      arr_valid_o <= seq_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (seq_valid_i) begin
      arr_data_o <= seq_cast_i ? cast_word : seq_data_i;  // Bypass keeps FP16 as is.
      arr_addr_o <= seq_addr_i;
      arr_last_o <= seq_last_i;
      arr_cast_o <= seq_cast_i;
    end
  end

  a_cast_upper_zero : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (arr_valid_o && arr_cast_o) |-> (arr_data_o[DATA_W-1:PACK_W] == '0)
  ) else $error("cast row has nonzero upper half");

endmodule

//--- rtl/castout_store.sv
`timescale 1ns/10ps

module castout_store
  import castout_bus_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          arr_valid_i,
  input  logic [NUM_LANES*LANE_W-1:0]   arr_data_i,
  input  logic [ADDR_W-1:0]             arr_addr_i,
  input  logic                          arr_last_i,
  input  logic                          arr_cast_i,
  output logic                          wr_o,
  output logic [ADDR_W-1:0]             wr_addr_o,
  output logic [NUM_LANES*LANE_W-1:0]   wr_data_o,
  output logic [NUM_LANES*2-1:0]        wr_be_o,
  output logic                          done_o
);

  localparam int unsigned DATA_W = NUM_LANES * LANE_W;
  localparam int unsigned BE_W   = DATA_W / BYTE_W;    // Two enables per lane.

  logic [BE_W-1:0] be_next;

  // A cast row only fills one byte per lane.
  assign be_next = arr_cast_i ? {{NUM_LANES{1'b0}}, {NUM_LANES{1'b1}}} : '1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_o   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      wr_o   <= arr_valid_i;
      done_o <= arr_valid_i && arr_last_i;  // Same cycle as the last write.
    end
  end

  always_ff @(posedge clk_i) begin
    if (arr_valid_i) begin
      wr_addr_o <= arr_addr_i;
      wr_data_o <= arr_data_i;
      wr_be_o   <= be_next;
    end
  end

  a_be_on_write : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) wr_o |-> (wr_be_o != '0)
  ) else $error("write issued with no byte enable");

endmodule

//--- rtl/castout_top.sv
`timescale 1ns/10ps

module castout_top
  import castout_bus_pkg::*;
  import castout_fmt_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  logic [ADDR_W-1:0]             base_addr_i,
  input  logic [ADDR_W-1:0]             stride_i,
  input  logic [ROW_W-1:0]              rows_i,
  input  logic                          cast_i,
  input  fp8_fmt_e                      dst_fmt_i,
  input  logic                          valid_i,
  input  logic [NUM_LANES*LANE_W-1:0]   data_i,
  output logic                          busy_o,
  output logic                          wr_o,
  output logic [ADDR_W-1:0]             wr_addr_o,
  output logic [NUM_LANES*LANE_W-1:0]   wr_data_o,
  output logic [NUM_LANES*2-1:0]        wr_be_o,
  output logic                          done_o
);

  localparam int unsigned DATA_W = NUM_LANES * LANE_W;

  logic              seq_valid;
  logic [DATA_W-1:0] seq_data;
  logic [ADDR_W-1:0] seq_addr;
  logic              seq_last;
  logic              seq_cast;
  fp8_fmt_e          seq_fmt;

  logic              arr_valid;
  logic [DATA_W-1:0] arr_data;
  logic [ADDR_W-1:0] arr_addr;
  logic              arr_last;
  logic              arr_cast;

  castout_row_seq #(
    .NUM_LANES (NUM_LANES)
  ) row_seq_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .stride_i    (stride_i),
    .rows_i      (rows_i),
    .cast_i      (cast_i),
    .dst_fmt_i   (dst_fmt_i),
    .valid_i     (valid_i),
    .data_i      (data_i),
    .busy_o      (busy_o),
    .seq_valid_o (seq_valid),
    .seq_data_o  (seq_data),
    .seq_addr_o  (seq_addr),
    .seq_last_o  (seq_last),
    .seq_cast_o  (seq_cast),
    .seq_fmt_o   (seq_fmt)
  );

  castout_array #(
    .NUM_LANES (NUM_LANES)
  ) array_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .seq_valid_i (seq_valid),
    .seq_data_i  (seq_data),
    .seq_addr_i  (seq_addr),
    .seq_last_i  (seq_last),
    .seq_cast_i  (seq_cast),
    .seq_fmt_i   (seq_fmt),
    .arr_valid_o (arr_valid),
    .arr_data_o  (arr_data),
    .arr_addr_o  (arr_addr),
    .arr_last_o  (arr_last),
    .arr_cast_o  (arr_cast)
  );

  castout_store #(
    .NUM_LANES (NUM_LANES)
  ) store_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .arr_valid_i (arr_valid),
    .arr_data_i  (arr_data),
    .arr_addr_i  (arr_addr),
    .arr_last_i  (arr_last),
    .arr_cast_i  (arr_cast),
    .wr_o        (wr_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .wr_be_o     (wr_be_o),
    .done_o      (done_o)
  );

endmodule

//--- sim/castout_tb.sv
`timescale 1ns/10ps

module castout_tb
  import castout_bus_pkg::*;
  import castout_fmt_pkg::*;
();

  localparam int unsigned NUM_LANES = 4;
  localparam int unsigned DATA_W    = NUM_LANES * LANE_W;
  localparam int unsigned BE_W      = NUM_LANES * 2;
  localparam int          WAIT_CYCLES = 40;                    // Per wait for writes.
  localparam int          WATCHDOG_CYCLES = 6 * (WAIT_CYCLES + 30) + 200;
  localparam logic [15:0] E4M3_CASES [16] = '{
    16'h0000, 16'h8000, 16'h7C00, 16'hFC00,                    // Zeros, infinities.
    16'h7E00, 16'hFD01, 16'h5F40, 16'h5F41,                    // NaNs, 464 and above.
    16'h7BFF, 16'h2000, 16'h1400, 16'h1401,                    // Max FP16, subnormal range.
    16'h1A00, 16'h3C40, 16'h3CC0, 16'h0001                     // Halfway cases.
  };

  logic              clk = 1'b0;
  logic              rst_n, clear, start, cast, valid;
  logic [ADDR_W-1:0] base_addr, stride;
  logic [ROW_W-1:0]  rows;
  fp8_fmt_e          dst_fmt;
  logic [DATA_W-1:0] data;
  logic              busy, wr, done;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [BE_W-1:0]   wr_be;

  logic [DATA_W-1:0] exp_data [$];
  logic [DATA_W-1:0] obs_data [$];
  logic [ADDR_W-1:0] exp_addr [$];
  logic [ADDR_W-1:0] obs_addr [$];
  logic [BE_W-1:0]   exp_be [$];
  logic [BE_W-1:0]   obs_be [$];
  int                exp_edge [$];
  int                obs_edge [$];
  logic              exp_last [$];
  logic              obs_done [$];

  int                edge_cnt = 0;
  int                err_cnt = 0;
  int                pass_tests = 0;
  int                fail_tests = 0;
  int                stray_done = 0;
  integer            seed = 32'hb0ed_9031;
  logic [ADDR_W-1:0] job_addr;                                 // Model of the next row address.
  logic [ADDR_W-1:0] job_stride;
  logic              job_cast;
  fp8_fmt_e          job_fmt;

  castout_top #(.NUM_LANES(NUM_LANES)) castout_top_i (
    .clk_i(clk), .rst_n_i(rst_n), .clear_i(clear), .start_i(start),
    .base_addr_i(base_addr), .stride_i(stride), .rows_i(rows), .cast_i(cast),
    .dst_fmt_i(dst_fmt), .valid_i(valid), .data_i(data), .busy_o(busy),
    .wr_o(wr), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .wr_be_o(wr_be), .done_o(done)
  );

  always #4 clk = ~clk;                                        // 8 ns period.

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  // Writes are taken mid-cycle and tagged with the edge that samples them.
  always @(negedge clk) begin
    if (wr === 1'b1) begin
      obs_data.push_back(wr_data);
      obs_addr.push_back(wr_addr);
      obs_be.push_back(wr_be);
      obs_edge.push_back(edge_cnt + 1);
      obs_done.push_back(done);
    end else if (done === 1'b1) begin
      stray_done++;
    end
  end

  // Round a FP16 value onto the FP8 grid, nearest even.
  function automatic fp8_u ref_cast(input fp16_t h, input fp8_fmt_e fmt);
    int   man_bits, bias, m, big_e, te, s, units, rem, half, code;
    fp8_u r;
    man_bits = (fmt == FMT_E4M3) ? 3 : 2;
    bias     = (fmt == FMT_E4M3) ? 7 : 15;
    if (h.exp == 5'h1F) begin
      if (h.man != '0) code = (fmt == FMT_E4M3) ? int'(E4M3_NAN) : int'(E5M2_QNAN);
      else code = (fmt == FMT_E4M3) ? int'(E4M3_MAX_MAG) : 'h7C;
    end else begin
      m     = (h.exp == '0) ? int'(h.man) : int'({1'b1, h.man});
      big_e = (h.exp == '0) ? -14 : int'(h.exp) - 15;
      te    = (big_e > 1 - bias) ? big_e : 1 - bias;          // Clamp to the subnormal binade.
      s     = te - man_bits - (big_e - 10);                   // Bits below the result quantum.
      units = m >> s;
      rem   = m & ((1 << s) - 1);
      half  = 1 << (s - 1);
      if (rem > half || (rem == half && units[0])) units = units + 1;
      code = ((te + bias - 1) << man_bits) + units;           // Carry runs into the exponent.
      if (fmt == FMT_E4M3 && code > 'h7E) code = 'h7E;
      if (fmt == FMT_E5M2 && code > 'h7C) code = 'h7C;
    end
    r.raw = {h.sign, code[6:0]};
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] expected_word(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] w;
    fp8_u              b;
    if (!job_cast) return d;
    w = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      b = ref_cast(fp16_t'(d[k*LANE_W +: LANE_W]), job_fmt);
      w[k*BYTE_W +: BYTE_W] = b.raw;                          // Lane k lands in byte k.
    end
    return w;
  endfunction

  // A byte is enabled when it carries data. A cast row fills one byte per lane.
  function automatic logic [BE_W-1:0] expected_be(input logic cast_row);
    logic [BE_W-1:0] be;
    for (int b = 0; b < BE_W; b++) be[b] = !cast_row || (b < NUM_LANES);
    return be;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    for (int k = 0; k < NUM_LANES; k++) w[k*LANE_W +: LANE_W] = 16'($random(seed));
    return w;
  endfunction

  task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_be(input string name, input logic [BE_W-1:0] got, exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_byte(input string name, input fp8_u got, exp);
    if (got.raw !== exp.raw) begin
      $display("Mismatch %s: got %h, expected %h", name, got.raw, exp.raw);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic start_job(input logic [ADDR_W-1:0] b, st, input logic [ROW_W-1:0] n,
                           input logic c, input fp8_fmt_e f, input logic accepted);
    step();
    base_addr = b;
    stride    = st;
    rows      = n;
    cast      = c;
    dst_fmt   = f;
    start     = 1'b1;
    if (accepted) begin
      job_addr   = b;
      job_stride = st;
      job_cast   = c;
      job_fmt    = f;
    end
    step();
    start = 1'b0;
  endtask

  task automatic send_row(input logic [DATA_W-1:0] d, input logic expect_wr, last);
    valid = 1'b1;
    data  = d;
    if (expect_wr) begin
      exp_data.push_back(expected_word(d));
      exp_addr.push_back(job_addr);
      exp_be.push_back(expected_be(job_cast));
      exp_edge.push_back(edge_cnt + 1);
      exp_last.push_back(last);
      job_addr = job_addr + job_stride;
    end
    step();
    valid = 1'b0;
  endtask

  task automatic wait_writes(input int n);
    int waited;
    waited = 0;
    while (obs_data.size() < n && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (obs_data.size() < n) begin
      $display("Timed out waiting for %0d writes, only %0d seen", n, obs_data.size());
      err_cnt++;
    end
    repeat (6) @(negedge clk);                                // Catch any late extra write.
    step();
  endtask

  task automatic compare_writes(input logic by_byte);
    int ee, oe;
    if (obs_data.size() != exp_data.size()) begin
      $display("Expected %0d writes but saw %0d", exp_data.size(), obs_data.size());
      err_cnt++;
    end
    while (exp_data.size() > 0 && obs_data.size() > 0) begin
      if (by_byte) begin
        for (int k = 0; k < BE_W; k++)
          check_byte($sformatf("wr_data_o byte %0d", k),
                     fp8_u'(obs_data[0][k*BYTE_W +: BYTE_W]),
                     fp8_u'(exp_data[0][k*BYTE_W +: BYTE_W]));
      end else begin
        check_word("wr_data_o", obs_data[0], exp_data[0]);
      end
      check_addr("wr_addr_o", obs_addr.pop_front(), exp_addr.pop_front());
      check_be("wr_be_o", obs_be.pop_front(), exp_be.pop_front());
      check_flag("done_o", obs_done.pop_front(), exp_last.pop_front());
      ee = exp_edge.pop_front();
      oe = obs_edge.pop_front();
      if (oe != ee + 3) begin
        $display("Row sampled at edge %0d was written at edge %0d, not 3 edges later", ee, oe);
        err_cnt++;
      end
      void'(obs_data.pop_front());
      void'(exp_data.pop_front());
    end
    exp_data.delete();
    obs_data.delete();
    exp_addr.delete();
    obs_addr.delete();
    exp_be.delete();
    obs_be.delete();
    exp_edge.delete();
    obs_edge.delete();
    exp_last.delete();
    obs_done.delete();
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) pass_tests++;
    else fail_tests++;
    $display("%-16s %s", name, (err_cnt == errs_before) ? "PASS" : "FAIL");
  endtask

  task automatic idle_after_reset();
    int e0 = err_cnt;
    check_flag("wr_o", wr, 1'b0);
    check_flag("done_o", done, 1'b0);
    check_flag("busy_o", busy, 1'b0);
    send_row(rand_word(), 1'b0, 1'b0);                        // No job, no write.
    wait_writes(0);
    compare_writes(1'b0);
    report_test("reset_idle", e0);
  endtask

  task automatic bypass_job();
    int e0 = err_cnt;
    start_job(32'h0000_1000, 32'h40, 16'd7, 1'b0, FMT_E5M2, 1'b1);
    for (int r = 0; r < 7; r++) begin
      send_row(rand_word(), 1'b1, r == 6);
      repeat ({$random(seed)} % 3) step();
    end
    wait_writes(7);
    compare_writes(1'b0);
    check_flag("busy_o", busy, 1'b0);
    report_test("bypass", e0);
  endtask

  task automatic e5m2_cast_job();
    int e0 = err_cnt;
    start_job(32'h2000_0000, 32'h10, 16'd8, 1'b1, FMT_E5M2, 1'b1);
    for (int r = 0; r < 8; r++) send_row(rand_word(), 1'b1, r == 7);
    wait_writes(8);
    compare_writes(1'b0);
    report_test("cast_e5m2", e0);
  endtask

  task automatic e4m3_specials_job();
    int                e0 = err_cnt;
    logic [DATA_W-1:0] w;
    start_job(32'h0000_3000, 32'h8, 16'd4, 1'b1, FMT_E4M3, 1'b1);
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < NUM_LANES; k++) w[k*LANE_W +: LANE_W] = E4M3_CASES[r*4 + k];
      send_row(w, 1'b1, r == 3);
    end
    wait_writes(4);
    compare_writes(1'b1);
    report_test("cast_e4m3", e0);
  endtask

  task automatic job_boundaries();
    int e0 = err_cnt;
    start_job(32'h0000_4000, 32'h100, 16'd3, 1'b0, FMT_E5M2, 1'b1);
    send_row(rand_word(), 1'b1, 1'b0);
    start_job(32'hDEAD_0000, 32'h4, 16'd9, 1'b1, FMT_E4M3, 1'b0);  // Ignored while busy.
    send_row(rand_word(), 1'b1, 1'b0);
    step();
    send_row(rand_word(), 1'b1, 1'b1);
    send_row(rand_word(), 1'b0, 1'b0);                        // Strobes past the last row.
    send_row(rand_word(), 1'b0, 1'b0);
    wait_writes(3);
    compare_writes(1'b0);
    check_flag("busy_o", busy, 1'b0);
    if (stray_done != 0) begin
      $display("done_o pulsed %0d times without a write", stray_done);
      err_cnt++;
    end
    report_test("job_bounds", e0);
  endtask

  task automatic clear_mid_job();
    int e0 = err_cnt;
    start_job(32'h0000_5000, 32'h20, 16'd6, 1'b0, FMT_E5M2, 1'b1);
    send_row(rand_word(), 1'b0, 1'b0);                        // Still in flight at the clear.
    send_row(rand_word(), 1'b0, 1'b0);
    clear = 1'b1;
    step();
    clear = 1'b0;
    check_flag("busy_o", busy, 1'b0);
    send_row(rand_word(), 1'b0, 1'b0);
    send_row(rand_word(), 1'b0, 1'b0);
    wait_writes(0);
    compare_writes(1'b0);
    check_flag("busy_o", busy, 1'b0);
    report_test("clear_abort", e0);
  endtask

  initial begin
    rst_n     = 1'b0;
    clear     = 1'b0;
    start     = 1'b0;
    cast      = 1'b0;
    valid     = 1'b0;
    base_addr = '0;
    stride    = '0;
    rows      = '0;
    dst_fmt   = FMT_E5M2;
    data      = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    idle_after_reset();
    bypass_job();
    e5m2_cast_job();
    e4m3_specials_job();
    job_boundaries();
    clear_mid_job();
    $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sources.f
rtl/castout_fmt_pkg.sv
rtl/castout_bus_pkg.sv
rtl/castout_lane_cast.sv
rtl/castout_row_seq.sv
rtl/castout_array.sv
rtl/castout_store.sv
rtl/castout_top.sv
sim/castout_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the castout testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module castout_tb \
  -f sources.f \
  -o castout_sim

# The log decides the result, so a pipe status is not needed here.
./obj_dir/castout_sim | tee sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi
